// File: verilog/if_stage_defines.svh
//////////////////////////////
// constants shared by the fetch stage RTL and its testbench
// include wherever a width, step or debug address is needed
//////////////////////////////

`ifndef IF_STAGE_DEFINES_SVH
`define IF_STAGE_DEFINES_SVH

// address and instruction word width
`define XLEN 32

// debug module entry points
`define DM_HALT_ADDR 32'h1A110800
`define DM_EXC_ADDR  32'h1A110808

// sequential pc increments, full word and compressed
`define INSTR_STEP_FULL 4
`define INSTR_STEP_HALF 2

`endif

// File: verilog/if_stage_pkg.sv
//////////////////////////////
// selector enums and bundled fetch / IF-ID payloads
// imported by every fetch stage module
//////////////////////////////

`include "if_stage_defines.svh"

package if_stage_pkg;

  // source of the next fetch pc
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of trap target
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // word offered by the prefetch unit
  typedef struct packed {
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] addr;
    logic             err;
  } fetch_rsp_t;

  // contents of the IF-ID register
  typedef struct packed {
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] pc;
    logic             is_compressed;
    logic             fetch_err;
  } id_instr_t;

endpackage

// File: verilog/fetch_addr_sel.sv
//////////////////////////////
// next fetch address mux with trap vector generation
// purely combinational, driven by the controller's pc set strobe
//////////////////////////////

`timescale 1ns/1ps

`include "if_stage_defines.svh"

module fetch_addr_sel import if_stage_pkg::*; (
  input  logic             pc_set_i,
  input  pc_sel_e          pc_mux_i,
  input  exc_pc_sel_e      exc_pc_mux_i,
  input  logic [4:0]       irq_id_i,
  input  logic [`XLEN-1:0] boot_addr_i,
  input  logic [`XLEN-1:0] branch_target_i,
  input  logic [`XLEN-1:0] csr_mtvec_i,
  input  logic [`XLEN-1:0] csr_mepc_i,
  input  logic [`XLEN-1:0] csr_depc_i,
  output logic [`XLEN-1:0] fetch_addr_o,
  output logic             fetch_branch_o,
  output logic             csr_mtvec_init_o
);

  // word aligned trap base, mode bits dropped
  logic [`XLEN-1:0] mtvec_base;
  logic [`XLEN-1:0] exc_pc;
  logic [`XLEN-1:0] fetch_addr_n;

  assign mtvec_base = {csr_mtvec_i[`XLEN-1:2], 2'b00};

  //////////////////////////////
  // trap vector
  //////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored mode, one word per interrupt id
      EXC_PC_IRQ:     exc_pc = mtvec_base + `XLEN'({irq_id_i, 2'b00});
      EXC_PC_DBD:     exc_pc = `DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  //////////////////////////////
  // next pc
  //////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n = boot_addr_i;
      PC_JUMP: fetch_addr_n = branch_target_i;
      // trap handler entry
      PC_EXC:  fetch_addr_n = exc_pc;
      // return from trap / debug
      PC_ERET: fetch_addr_n = csr_mepc_i;
      PC_DRET: fetch_addr_n = csr_depc_i;
      default: fetch_addr_n = boot_addr_i;
    endcase
  end

  // instructions are at least halfword aligned
  assign fetch_addr_o     = {fetch_addr_n[`XLEN-1:1], 1'b0};
  assign fetch_branch_o   = pc_set_i;

  // csr file loads its reset trap base when fetch restarts from boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// File: verilog/if_id_pipe.sv
//////////////////////////////
// IF-ID pipeline register with valid / new flags
// accepts words from the external prefetch unit
//////////////////////////////

`timescale 1ns/1ps

module if_id_pipe import if_stage_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_valid_i,
  input  fetch_rsp_t fetch_rsp_i,
  input  logic       id_in_ready_i,
  input  logic       pc_set_i,
  input  logic       instr_valid_clear_i,
  output logic       fetch_ready_o,
  output logic       accept_o,
  output id_instr_t  id_instr_o,
  output logic       instr_valid_id_o,
  output logic       instr_new_id_o
);

  logic      accept;
  logic      valid_d;
  logic      valid_q;
  logic      new_q;
  id_instr_t id_instr_d;
  id_instr_t id_instr_q;

  // prefetch unit holds its word until ID can take it
  assign fetch_ready_o = id_in_ready_i;
  assign accept        = fetch_valid_i & id_in_ready_i;
  assign accept_o      = accept;

  //////////////////////////////
  // payload
  //////////////////////////////

  always_comb begin
    id_instr_d.rdata         = fetch_rsp_i.rdata;
    id_instr_d.pc            = fetch_rsp_i.addr;
    // low bits other than 2'b11 mark a 16 bit encoding
    id_instr_d.is_compressed = (fetch_rsp_i.rdata[1:0] != 2'b11);
    id_instr_d.fetch_err     = fetch_rsp_i.err;
  end

  // frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_instr_q <= id_instr_d;
    end
  end

  //////////////////////////////
  // flags
  //////////////////////////////

  // accepted word is squashed by a concurrent pc set
  // valid then holds until the controller clears it
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one cycle pulse per accepted word
      new_q   <= accept;
    end
  end

  assign id_instr_o       = id_instr_q;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// File: verilog/pc_seq_check.sv
//////////////////////////////
// hardening check on sequential pc increments
// alerts when fetch pc is not ID pc + 2 / + 4
//////////////////////////////

`timescale 1ns/1ps

`include "if_stage_defines.svh"

module pc_seq_check import if_stage_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             accept_i,
  input  logic             pc_set_i,
  input  id_instr_t        id_instr_i,
  input  logic [`XLEN-1:0] pc_if_i,
  output logic             pc_mismatch_alert_o
);

  logic             seq_d;
  logic             seq_q;
  logic             step_half;
  logic [`XLEN-1:0] pc_expected;

  // flow is sequential from the first accept after reset or a pc set
  // any jump, trap or return breaks it again
  assign seq_d = (seq_q | accept_i) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  // faulting fetch counts as a full word
  assign step_half = id_instr_i.is_compressed & ~id_instr_i.fetch_err;

  assign pc_expected = id_instr_i.pc +
                       (step_half ? `XLEN'(`INSTR_STEP_HALF) : `XLEN'(`INSTR_STEP_FULL));

  assign pc_mismatch_alert_o = seq_q & (pc_if_i != pc_expected);

endmodule

// File: verilog/if_stage.sv
//////////////////////////////
// instruction fetch stage control core
// pc selection, IF-ID capture and pc increment check
//////////////////////////////

`timescale 1ns/1ps

`include "if_stage_defines.svh"

module if_stage import if_stage_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,

  // pc control
  input  logic             pc_set_i,
  input  pc_sel_e          pc_mux_i,
  input  exc_pc_sel_e      exc_pc_mux_i,
  input  logic [4:0]       irq_id_i,
  input  logic [`XLEN-1:0] boot_addr_i,
  input  logic [`XLEN-1:0] branch_target_i,
  input  logic [`XLEN-1:0] csr_mtvec_i,
  input  logic [`XLEN-1:0] csr_mepc_i,
  input  logic [`XLEN-1:0] csr_depc_i,
  output logic             csr_mtvec_init_o,

  // prefetch unit
  output logic [`XLEN-1:0] fetch_addr_o,
  output logic             fetch_branch_o,
  input  logic             fetch_valid_i,
  input  fetch_rsp_t       fetch_rsp_i,
  output logic             fetch_ready_o,

  // ID side
  input  logic             id_in_ready_i,
  input  logic             instr_valid_clear_i,
  output logic             instr_valid_id_o,
  output logic             instr_new_id_o,
  output logic [`XLEN-1:0] instr_rdata_id_o,
  output logic [`XLEN-1:0] pc_id_o,
  output logic             instr_is_compressed_id_o,
  output logic             instr_fetch_err_o,

  // misc
  output logic [`XLEN-1:0] pc_if_o,
  output logic             pc_mismatch_alert_o
);

  logic      accept;
  id_instr_t id_instr;

  fetch_addr_sel u_fetch_addr_sel (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .fetch_addr_o     (fetch_addr_o),
    .fetch_branch_o   (fetch_branch_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_id_pipe u_if_id_pipe (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_rsp_i         (fetch_rsp_i),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready_o),
    .accept_o            (accept),
    .id_instr_o          (id_instr),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o)
  );

  // fetch pc is the address of the word currently offered
  assign pc_if_o = fetch_rsp_i.addr;

  pc_seq_check u_pc_seq_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .accept_i            (accept),
    .pc_set_i            (pc_set_i),
    .id_instr_i          (id_instr),
    .pc_if_i             (pc_if_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // unpack the IF-ID register onto the ID ports
  assign instr_rdata_id_o         = id_instr.rdata;
  assign pc_id_o                  = id_instr.pc;
  assign instr_is_compressed_id_o = id_instr.is_compressed;
  assign instr_fetch_err_o        = id_instr.fetch_err;

endmodule

// File: sim/if_stage_chk.sv
//////////////////////////////
// concurrent checks on the fetch stage ports
// bound to if_stage from the testbench
//////////////////////////////

`timescale 1ns/1ps

`include "if_stage_defines.svh"

module if_stage_chk import if_stage_pkg::*; (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             pc_set_i,
  input pc_sel_e          pc_mux_i,
  input logic [`XLEN-1:0] boot_addr_i,
  input logic [`XLEN-1:0] fetch_addr_o,
  input logic             fetch_valid_i,
  input logic             id_in_ready_i,
  input logic             instr_new_id_o
);

  // fetch never targets an odd address
  addr_halfword: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_addr_o[0] == 1'b0)
    else $error("fetch address has bit 0 set");

  boot_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[7:0] == 8'h00)
    else $error("boot address not aligned to 256 bytes");

  // new is only raised in the cycle right after an accept
  new_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> $past(fetch_valid_i && id_in_ready_i))
    else $error("new flag raised without an accept in the cycle before");

  mux_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> !$isunknown(pc_mux_i))
    else $error("pc select unknown while pc set is high");

endmodule

// File: sim/if_stage_tb.sv
//////////////////////////////
// randomized testbench for the fetch stage control core
// a cycle model predicts every output just before each rising edge
//////////////////////////////

`timescale 1ns/1ps

`include "if_stage_defines.svh"

module if_stage_tb import if_stage_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int N_ACCEPTS  = 400;
  localparam int MAX_CYCLES = 4000;

  logic             clk_i;
  logic             rst_ni;
  logic             pc_set_i;
  pc_sel_e          pc_mux_i;
  exc_pc_sel_e      exc_pc_mux_i;
  logic [4:0]       irq_id_i;
  logic [`XLEN-1:0] boot_addr_i;
  logic [`XLEN-1:0] branch_target_i;
  logic [`XLEN-1:0] csr_mtvec_i;
  logic [`XLEN-1:0] csr_mepc_i;
  logic [`XLEN-1:0] csr_depc_i;
  logic             fetch_valid_i;
  fetch_rsp_t       fetch_rsp_i;
  logic             id_in_ready_i;
  logic             instr_valid_clear_i;
  logic [`XLEN-1:0] fetch_addr_o;
  logic [`XLEN-1:0] instr_rdata_id_o;
  logic [`XLEN-1:0] pc_id_o;
  logic [`XLEN-1:0] pc_if_o;
  logic             fetch_branch_o;
  logic             csr_mtvec_init_o;
  logic             fetch_ready_o;
  logic             instr_valid_id_o;
  logic             instr_new_id_o;
  logic             instr_is_compressed_id_o;
  logic             instr_fetch_err_o;
  logic             pc_mismatch_alert_o;

  // model state, mirrors the registers of the stage
  logic             m_valid;
  logic             m_new;
  logic             m_seq;
  logic             m_loaded;
  id_instr_t        m_id;
  // prefetch stand-in, keeps an untaken word and walks sequentially
  logic             held;
  logic [`XLEN-1:0] seq_addr;
  int               accepts;
  int               cycles;

  if_stage UUT (.*);

  bind if_stage if_stage_chk u_chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pc_set_i       (pc_set_i),
    .pc_mux_i       (pc_mux_i),
    .boot_addr_i    (boot_addr_i),
    .fetch_addr_o   (fetch_addr_o),
    .fetch_valid_i  (fetch_valid_i),
    .id_in_ready_i  (id_in_ready_i),
    .instr_new_id_o (instr_new_id_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic expect_word(input string name, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] act);
    assert (act === exp) else begin
      $display("Mismatch at %0d ns: %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic expect_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("Mismatch at %0d ns: %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // compressed words advance by a halfword unless the fetch faulted
  function automatic logic [`XLEN-1:0] pc_step(input id_instr_t w);
    if (w.is_compressed && !w.fetch_err) begin
      return `INSTR_STEP_HALF;
    end
    return `INSTR_STEP_FULL;
  endfunction

  task automatic init_inputs();
    rst_ni              = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    irq_id_i            = '0;
    boot_addr_i         = '0;
    branch_target_i     = '0;
    csr_mtvec_i         = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    fetch_valid_i       = 1'b0;
    fetch_rsp_i         = '0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
  endtask

  task automatic drive_inputs();
    pc_set_i            = ($urandom % 8) == 0;
    pc_mux_i            = pc_sel_e'(3'($urandom % 5));
    exc_pc_mux_i        = exc_pc_sel_e'(2'($urandom % 4));
    irq_id_i            = 5'($urandom);
    boot_addr_i         = $urandom & 32'hFFFF_FF00;
    branch_target_i     = $urandom;
    csr_mtvec_i         = $urandom;
    csr_mepc_i          = $urandom;
    csr_depc_i          = $urandom;
    id_in_ready_i       = ($urandom % 4) != 0;
    instr_valid_clear_i = ($urandom % 6) == 0;
    if (!held) begin
      fetch_valid_i     = ($urandom % 4) != 0;
      fetch_rsp_i.rdata = $urandom;
      fetch_rsp_i.err   = ($urandom % 16) == 0;
      // mostly sequential, now and then a jump
      fetch_rsp_i.addr  = (($urandom % 8) == 0) ? ($urandom & ~32'h1) : seq_addr;
    end
  endtask

  //////////////////////////////
  // model and checks
  //////////////////////////////

  task automatic verify_outputs();
    logic [`XLEN-1:0] exp_exc;
    logic [`XLEN-1:0] exp_addr;
    logic             exp_alert;
    case (exc_pc_mux_i)
      EXC_PC_EXC: exp_exc = csr_mtvec_i & ~32'h3;
      EXC_PC_IRQ: exp_exc = (csr_mtvec_i & ~32'h3) + 32'(irq_id_i) * 4;
      EXC_PC_DBD: exp_exc = `DM_HALT_ADDR;
      default:    exp_exc = `DM_EXC_ADDR;
    endcase
    case (pc_mux_i)
      PC_BOOT: exp_addr = boot_addr_i;
      PC_JUMP: exp_addr = branch_target_i;
      PC_EXC:  exp_addr = exp_exc;
      PC_ERET: exp_addr = csr_mepc_i;
      default: exp_addr = csr_depc_i;
    endcase
    exp_addr[0] = 1'b0;
    exp_alert   = m_seq && (fetch_rsp_i.addr != m_id.pc + pc_step(m_id));
    expect_word("fetch_addr_o", exp_addr, fetch_addr_o);
    expect_flag("fetch_branch_o", pc_set_i, fetch_branch_o);
    expect_flag("csr_mtvec_init_o", pc_set_i && pc_mux_i == PC_BOOT, csr_mtvec_init_o);
    expect_flag("fetch_ready_o", id_in_ready_i, fetch_ready_o);
    expect_word("pc_if_o", fetch_rsp_i.addr, pc_if_o);
    expect_flag("instr_valid_id_o", m_valid, instr_valid_id_o);
    expect_flag("instr_new_id_o", m_new, instr_new_id_o);
    expect_flag("pc_mismatch_alert_o", exp_alert, pc_mismatch_alert_o);
    // data register is unknown until the first accept
    if (m_loaded) begin
      expect_word("instr_rdata_id_o", m_id.rdata, instr_rdata_id_o);
      expect_word("pc_id_o", m_id.pc, pc_id_o);
      expect_flag("instr_is_compressed_id_o", m_id.is_compressed, instr_is_compressed_id_o);
      expect_flag("instr_fetch_err_o", m_id.fetch_err, instr_fetch_err_o);
    end
  endtask

  // state after the coming rising edge
  task automatic advance_model();
    logic accept;
    accept  = fetch_valid_i && id_in_ready_i;
    m_valid = (accept && !pc_set_i) || (m_valid && !instr_valid_clear_i);
    m_new   = accept;
    m_seq   = (m_seq || accept) && !pc_set_i;
    held    = fetch_valid_i && !id_in_ready_i;
    if (accept) begin
      m_id.rdata         = fetch_rsp_i.rdata;
      m_id.pc            = fetch_rsp_i.addr;
      m_id.is_compressed = fetch_rsp_i.rdata[1:0] != 2'b11;
      m_id.fetch_err     = fetch_rsp_i.err;
      m_loaded           = 1'b1;
      seq_addr           = m_id.pc + pc_step(m_id);
      accepts++;
    end
  endtask

  initial begin
    void'($urandom(32'h4fa59150));
    init_inputs();
    m_valid  = 1'b0;
    m_new    = 1'b0;
    m_seq    = 1'b0;
    m_loaded = 1'b0;
    m_id     = '0;
    held     = 1'b0;
    seq_addr = 32'h0000_1000;
    accepts  = 0;
    cycles   = 0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    // run until enough words went through ID
    while (accepts < N_ACCEPTS) begin
      if (cycles >= MAX_CYCLES) begin
        $display("timeout after %0d cycles with only %0d words accepted", cycles, accepts);
        abort_run();
      end
      drive_inputs();
      #(CLK_PERIOD / 4);
      verify_outputs();
      advance_model();
      @(negedge clk_i);
      cycles++;
    end
    $display("%0d words accepted in %0d cycles", accepts, cycles);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: if_stage.f
+incdir+verilog
verilog/if_stage_pkg.sv
verilog/fetch_addr_sel.sv
verilog/if_id_pipe.sv
verilog/pc_seq_check.sv
verilog/if_stage.sv
sim/if_stage_chk.sv
sim/if_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module if_stage_tb -f if_stage.f -o if_stage_sim

./obj_dir/if_stage_sim | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
